// ==== list.f ====
verilog/warpPkg.sv
verilog/ioReqIf.sv
verilog/chipSelect.sv
verilog/refreshTimer.sv
verilog/ramControl.sv
verilog/ioBusSlave.sv
verilog/ioBusMaster.sv
verilog/fsbTerm.sv
verilog/warpSE.sv
tb/warpSE_assert.sv
tb/warpSETb.sv

// ==== Bender.yml ====
package:
  name: warp_se

sources:
  - verilog/warpPkg.sv
  - verilog/ioReqIf.sv
  - verilog/chipSelect.sv
  - verilog/refreshTimer.sv
  - verilog/ramControl.sv
  - verilog/ioBusSlave.sv
  - verilog/ioBusMaster.sv
  - verilog/fsbTerm.sv
  - verilog/warpSE.sv
  - target: test
    files:
      - tb/warpSE_assert.sv
      - tb/warpSETb.sv

// ==== tb/warpSETb.sv ====
`timescale 1ns/1ps

module warpSETb;

	localparam int refreshPeriod = 64;
	localparam int transactions = 200;
	// reset, worst case per transaction, then some margin
	localparam int cycleLimit = 16 + transactions * 40 + 500;

	logic FCLK;
	logic reset;
	warpPkg::addrT addr;
	logic nAs;
	logic nLds;
	logic nUds;
	logic nWe;
	logic nDtack;
	logic nBerr;
	warpPkg::raT ra;
	logic nRas;
	logic nCas;
	logic nRamLwe;
	logic nRamUwe;
	logic nOe;
	logic nRomOe;
	logic nAsIob;
	logic rnwIob;
	logic nLdsIob;
	logic nUdsIob;
	logic nDtackIob;
	logic nBerrIob;

	logic [15:0] lfsr;
	int cycles = 0;
	int refCount;
	logic refPrevCas;
	// set by the device model, read by the cpu model
	logic ioAnswered;
	logic ioBerrPick;

	warpSE #(
		.refreshPeriod(refreshPeriod)
	) u_dut(
		.*
	);

	// 4 ns period
	initial FCLK = 1'b0;
	always #2 FCLK = ~FCLK;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compareRa(input string name, input warpPkg::raT got, input warpPkg::raT exp);
		if (got !== exp) begin
			failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic compareDev(input string name, input warpPkg::devSelT got,
			input warpPkg::devSelT exp);
		if (got !== exp) begin
			failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic compareBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	// galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	// one step per bit, lsb first
	task automatic drawBits(input int width, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < width; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsrNext(lfsr);
		end
	endtask

	always @(posedge FCLK) begin
		cycles <= cycles + 1;
		if (cycles > cycleLimit) begin
			failRun($sformatf("timeout, run did not finish within %0d cycles", cycleLimit));
		end
	end

	always @(negedge FCLK) begin
		if (u_dut.protocolChecks.failCount != 0) begin
			failRun("a protocol assertion failed");
		end
		// cas before ras marks a refresh
		if (!reset && refPrevCas && !nCas && nRas) begin
			refCount = refCount + 1;
		end
		refPrevCas = nCas;
	end

	// peripheral device, answers 1..7 cycles after its strobe
	initial begin
		logic [31:0] v;
		int delay;
		forever begin
			@(negedge FCLK);
			if (!reset && !nAsIob) begin
				drawBits(3, v);
				delay = (v % 7) + 1;
				drawBits(3, v);
				// about one answer in eight is a bus error
				ioBerrPick = (v[2:0] == 3'd0);
				repeat (delay) @(negedge FCLK);
				ioAnswered = 1'b1;
				if (ioBerrPick) begin
					nBerrIob = 1'b0;
				end else begin
					nDtackIob = 1'b0;
				end
				@(negedge FCLK);
				while (!nAsIob) @(negedge FCLK);
				nDtackIob = 1'b1;
				nBerrIob = 1'b1;
			end
		end
	end

	// everything inactive before the first cycle
	task automatic checkIdle();
		compareBit("nDtack", nDtack, 1'b1);
		compareBit("nBerr", nBerr, 1'b1);
		compareBit("nRas", nRas, 1'b1);
		compareBit("nCas", nCas, 1'b1);
		compareBit("nRamLwe", nRamLwe, 1'b1);
		compareBit("nRamUwe", nRamUwe, 1'b1);
		compareBit("nOe", nOe, 1'b1);
		compareBit("nRomOe", nRomOe, 1'b1);
		compareBit("nAsIob", nAsIob, 1'b1);
		compareBit("nLdsIob", nLdsIob, 1'b1);
		compareBit("nUdsIob", nUdsIob, 1'b1);
		compareBit("rnwIob", rnwIob, 1'b1);
		compareDev("devSel", u_dut.devSel, warpPkg::devIdle);
	endtask

	// one cpu bus cycle, entered and left on a falling edge
	task automatic runCycle();
		logic [31:0] v;
		logic [1:0] region;
		warpPkg::addrT a;
		warpPkg::devSelT expDev;
		warpPkg::raT row;
		warpPkg::raT col;
		logic writing;
		logic [1:0] lanes;
		int gap;
		int rasFalls;
		logic casSeen;
		logic romSeen;
		logic ioSeen;
		logic prevRas;
		logic prevCas;
		logic prevAsIob;
		logic expBerr;

		drawBits(2, v);
		region = v[1:0];
		drawBits(19, v);
		a[19:1] = v[18:0];
		drawBits(3, v);
		// top nibble picks the target
		case (region)
			2'd0: begin
				a[23:20] = {2'b00, v[1:0]};
				expDev = warpPkg::devRam;
			end
			2'd1: begin
				a[23:20] = 4'h4;
				expDev = warpPkg::devRom;
			end
			2'd2: begin
				a[23:20] = {3'b111, v[0]};
				expDev = warpPkg::devIo;
			end
			default: begin
				// 5 to c, nothing mapped there
				a[23:20] = 4'h5 + v[2:0];
				expDev = warpPkg::devNone;
			end
		endcase
		drawBits(1, v);
		writing = v[0];
		drawBits(2, v);
		// a cpu cycle always has at least one strobe
		lanes = (v[1:0] == 2'b11) ? 2'b00 : v[1:0];
		drawBits(2, v);
		gap = v[1:0] + 1;
		// row a21..a12, column a11..a1
		row = {1'b0, a[21:12]};
		col = a[11:1];

		addr = a;
		nWe = !writing;
		nLds = lanes[0];
		nUds = lanes[1];
		nAs = 1'b0;
		ioAnswered = 1'b0;
		prevRas = nRas;
		prevCas = nCas;
		prevAsIob = nAsIob;
		rasFalls = 0;
		casSeen = 1'b0;
		romSeen = 1'b0;
		ioSeen = 1'b0;

		while (nDtack && nBerr) begin
			@(negedge FCLK);
			// ras falling with cas high all along is an access
			if (prevRas && !nRas && prevCas && nCas) begin
				rasFalls++;
				compareRa("ra row", ra, row);
			end
			if (prevCas && !nCas && !nRas) begin
				casSeen = 1'b1;
				compareRa("ra column", ra, col);
				compareBit("nRamLwe", nRamLwe, writing ? lanes[0] : 1'b1);
				compareBit("nRamUwe", nRamUwe, writing ? lanes[1] : 1'b1);
				compareBit("nOe", nOe, writing);
			end
			if (!nRomOe) begin
				romSeen = 1'b1;
			end
			if (prevAsIob && !nAsIob) begin
				ioSeen = 1'b1;
				compareBit("rnwIob", rnwIob, !writing);
				compareBit("nLdsIob", nLdsIob, lanes[0]);
				compareBit("nUdsIob", nUdsIob, lanes[1]);
			end
			// unmapped, no device strobe may move
			if (expDev == warpPkg::devNone) begin
				compareBit("nRamLwe", nRamLwe, 1'b1);
				compareBit("nRamUwe", nRamUwe, 1'b1);
				compareBit("nOe", nOe, 1'b1);
				compareBit("nRomOe", nRomOe, 1'b1);
				compareBit("nAsIob", nAsIob, 1'b1);
			end
			prevRas = nRas;
			prevCas = nCas;
			prevAsIob = nAsIob;
		end

		if (expDev == warpPkg::devIo && !ioAnswered) begin
			failRun("I/O cycle ended before the device answered");
		end
		expBerr = (expDev == warpPkg::devNone) || (expDev == warpPkg::devIo && ioBerrPick);
		compareBit("nDtack", nDtack, expBerr);
		compareBit("nBerr", nBerr, !expBerr);
		compareDev("devSel", u_dut.devSel, expDev);
		if (expDev == warpPkg::devRam && (rasFalls != 1 || !casSeen)) begin
			failRun("RAM cycle ended without one RAS then CAS access");
		end
		if (expDev != warpPkg::devRam && rasFalls != 0) begin
			failRun("RAS fell for an access outside a RAM cycle");
		end
		if (expDev == warpPkg::devRom && romSeen != !writing) begin
			failRun("ROM output enable did not follow the cycle direction");
		end
		if ((expDev == warpPkg::devIo) != ioSeen) begin
			failRun("peripheral cycle did not match the decoded target");
		end

		nAs = 1'b1;
		nLds = 1'b1;
		nUds = 1'b1;
		nWe = 1'b1;
		// termination drops two edges after as
		while (!nDtack || !nBerr) @(negedge FCLK);
		repeat (gap) @(negedge FCLK);
	endtask

	initial begin
		int n;
		int refMin;
		reset = 1'b1;
		addr = '0;
		nAs = 1'b1;
		nLds = 1'b1;
		nUds = 1'b1;
		nWe = 1'b1;
		nDtackIob = 1'b1;
		nBerrIob = 1'b1;
		lfsr = 16'd23;
		refCount = 0;
		refPrevCas = 1'b1;
		ioAnswered = 1'b0;
		ioBerrPick = 1'b0;
		repeat (16) @(negedge FCLK);
		reset = 1'b0;
		@(negedge FCLK);
		checkIdle();
		for (n = 0; n < transactions; n++) begin
			runCycle();
		end
		// one refresh per period, the last one may still be open
		refMin = (cycles - 16) / refreshPeriod - 1;
		if (refCount < refMin) begin
			failRun($sformatf("only %0d refresh cycles seen, at least %0d expected",
				refCount, refMin));
		end
		if (u_dut.protocolChecks.failCount == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			failRun("a protocol assertion failed");
		end
	end

endmodule

// ==== tb/warpSE_assert.sv ====
`timescale 1ns/1ps

module warpSEAssert(
	input logic FCLK,
	input logic reset,
	input logic req,
	input logic ack,
	input logic nRas,
	input logic nCas,
	input logic nDtack,
	input logic nBerr
);

	// failures seen so far, polled by the testbench
	int failCount = 0;

	// new request only once the old ack is gone
	reqRise: assert property (@(posedge FCLK) disable iff (reset)
		$rose(req) |-> !ack && !$past(ack))
	else begin
		failCount++;
		$error("req rose while ack was still high");
	end

	// ack is held until the slave has dropped req
	ackFall: assert property (@(posedge FCLK) disable iff (reset)
		$fell(ack) |-> !$past(req))
	else begin
		failCount++;
		$error("ack fell while req was still high");
	end

	// cas with ras low needs a ras phase before it
	casAfterRas: assert property (@(posedge FCLK) disable iff (reset)
		$fell(nCas) && !nRas |-> $past(!nRas))
	else begin
		failCount++;
		$error("cas fell with ras low but no ras phase before");
	end

	// a cycle ends one way only
	oneTerm: assert property (@(posedge FCLK) disable iff (reset)
		!(!nDtack && !nBerr))
	else begin
		failCount++;
		$error("dtack and berr asserted together");
	end

endmodule

bind warpSE warpSEAssert protocolChecks(
	.FCLK(FCLK),
	.reset(reset),
	.req(ioLink.req),
	.ack(ioLink.ack),
	.nRas(nRas),
	.nCas(nCas),
	.nDtack(nDtack),
	.nBerr(nBerr)
);

// ==== verilog/warpSE.sv ====
`timescale 1ns/1ps

module warpSE #(
	parameter int refreshPeriod = 64
)(
	input logic FCLK,
	input logic reset,
	input warpPkg::addrT addr,
	input logic nAs,
	input logic nLds,
	input logic nUds,
	input logic nWe,
	output logic nDtack,
	output logic nBerr,
	output warpPkg::raT ra,
	output logic nRas,
	output logic nCas,
	output logic nRamLwe,
	output logic nRamUwe,
	output logic nOe,
	output logic nRomOe,
	output logic nAsIob,
	output logic rnwIob,
	output logic nLdsIob,
	output logic nUdsIob,
	input logic nDtackIob,
	input logic nBerrIob
);

	// decoded target of the open cycle
	warpPkg::devSelT devSel;
	// refresh handshake
	logic refReq;
	logic refAck;
	// termination sources
	logic ramReady;
	logic ioReady;
	logic ioBerr;

	// slave to master link
	ioReqIf ioLink();

	chipSelect u_chipSelect(
		.FCLK(FCLK),
		.reset(reset),
		.addr(addr),
		.nAs(nAs),
		.devSel(devSel)
	);

	refreshTimer #(
		.refreshPeriod(refreshPeriod)
	) u_refreshTimer(
		.FCLK(FCLK),
		.reset(reset),
		.refReq(refReq),
		.refAck(refAck)
	);

	// dram and boot rom
	ramControl u_ramControl(
		.FCLK(FCLK),
		.reset(reset),
		.addr(addr),
		.nWe(nWe),
		.nLds(nLds),
		.nUds(nUds),
		.devSel(devSel),
		.refReq(refReq),
		.refAck(refAck),
		.ramReady(ramReady),
		.ra(ra),
		.nRas(nRas),
		.nCas(nCas),
		.nRamLwe(nRamLwe),
		.nRamUwe(nRamUwe),
		.nOe(nOe),
		.nRomOe(nRomOe)
	);

	ioBusSlave u_ioBusSlave(
		.FCLK(FCLK),
		.reset(reset),
		.devSel(devSel),
		.nWe(nWe),
		.nLds(nLds),
		.nUds(nUds),
		.io(ioLink.slave),
		.ioReady(ioReady),
		.ioBerr(ioBerr)
	);

	// peripheral bus side
	ioBusMaster u_ioBusMaster(
		.FCLK(FCLK),
		.reset(reset),
		.io(ioLink.master),
		.nAsIob(nAsIob),
		.rnwIob(rnwIob),
		.nLdsIob(nLdsIob),
		.nUdsIob(nUdsIob),
		.nDtackIob(nDtackIob),
		.nBerrIob(nBerrIob)
	);

	fsbTerm u_fsbTerm(
		.FCLK(FCLK),
		.reset(reset),
		.devSel(devSel),
		.ramReady(ramReady),
		.ioReady(ioReady),
		.ioBerr(ioBerr),
		.nDtack(nDtack),
		.nBerr(nBerr)
	);

endmodule

// ==== verilog/fsbTerm.sv ====
`timescale 1ns/1ps

module fsbTerm(
	input logic FCLK,
	input logic reset,
	input warpPkg::devSelT devSel,
	input logic ramReady,
	input logic ioReady,
	input logic ioBerr,
	output logic nDtack,
	output logic nBerr
);

	logic unmapped;

	// nothing answers in unmapped space
	assign unmapped = (devSel == warpPkg::devNone);

	always_ff @(posedge FCLK) begin
		if (reset) begin
			nDtack <= 1'b1;
			nBerr <= 1'b1;
		end else if (devSel == warpPkg::devIdle) begin
			// released once the cpu has dropped as
			nDtack <= 1'b1;
			nBerr <= 1'b1;
		end else begin
			// sticky until cycle end, io ready is only a pulse
			if (ramReady || ioReady) begin
				nDtack <= 1'b0;
			end
			if (ioBerr || unmapped) begin
				nBerr <= 1'b0;
			end
		end
	end

endmodule

// ==== verilog/ioBusMaster.sv ====
`timescale 1ns/1ps

module ioBusMaster(
	input logic FCLK,
	input logic reset,
	ioReqIf.master io,
	output logic nAsIob,
	output logic rnwIob,
	output logic nLdsIob,
	output logic nUdsIob,
	input logic nDtackIob,
	input logic nBerrIob
);

	warpPkg::ioStateT state;

	always_ff @(posedge FCLK) begin
		if (reset) begin
			state <= warpPkg::ioIdle;
			io.ack <= 1'b0;
			io.berr <= 1'b0;
			nAsIob <= 1'b1;
			rnwIob <= 1'b1;
			nLdsIob <= 1'b1;
			nUdsIob <= 1'b1;
		end else begin
			case (state)
				warpPkg::ioIdle: begin
					// direction set up one cycle ahead of as
					if (io.req && !io.ack) begin
						state <= warpPkg::ioStrobe;
						rnwIob <= !io.write;
					end
				end
				warpPkg::ioStrobe: begin
					state <= warpPkg::ioWait;
					nAsIob <= 1'b0;
					nLdsIob <= !io.lds;
					nUdsIob <= !io.uds;
				end
				warpPkg::ioWait: begin
					// slow devices stretch this state
					if (!nDtackIob || !nBerrIob) begin
						state <= warpPkg::ioAck;
						io.ack <= 1'b1;
						// bus error takes priority over dtack
						io.berr <= !nBerrIob;
						nAsIob <= 1'b1;
						rnwIob <= 1'b1;
						nLdsIob <= 1'b1;
						nUdsIob <= 1'b1;
					end
				end
				warpPkg::ioAck: begin
					// ack held until the slave drops req
					if (!io.req) begin
						state <= warpPkg::ioIdle;
						io.ack <= 1'b0;
						io.berr <= 1'b0;
					end
				end
				default: begin
					state <= warpPkg::ioIdle;
				end
			endcase
		end
	end

endmodule

// ==== verilog/ioBusSlave.sv ====
`timescale 1ns/1ps

module ioBusSlave(
	input logic FCLK,
	input logic reset,
	input warpPkg::devSelT devSel,
	input logic nWe,
	input logic nLds,
	input logic nUds,
	ioReqIf.slave io,
	output logic ioReady,
	output logic ioBerr
);

	logic done;
	logic start;

	// one request per io cycle, only after the link is fully idle
	assign start = (devSel == warpPkg::devIo) && !done && !io.req && !io.ack;

	always_ff @(posedge FCLK) begin
		if (reset) begin
			io.req <= 1'b0;
			done <= 1'b0;
			ioReady <= 1'b0;
			ioBerr <= 1'b0;
		end else begin
			// result strobes are single pulses
			ioReady <= 1'b0;
			ioBerr <= 1'b0;
			if (start) begin
				io.req <= 1'b1;
			end else if (io.req && io.ack) begin
				// drop req, master then drops ack
				io.req <= 1'b0;
				done <= 1'b1;
				ioReady <= !io.berr;
				ioBerr <= io.berr;
			end
			// rearm for the next cpu cycle
			if (devSel == warpPkg::devIdle) begin
				done <= 1'b0;
			end
		end
	end

	// attributes copied with req and held while it is open
	always_ff @(posedge FCLK) begin
		if (start) begin
			io.write <= !nWe;
			io.lds <= !nLds;
			io.uds <= !nUds;
		end
	end

endmodule

// ==== verilog/ramControl.sv ====
`timescale 1ns/1ps

module ramControl(
	input logic FCLK,
	input logic reset,
	input warpPkg::addrT addr,
	input logic nWe,
	input logic nLds,
	input logic nUds,
	input warpPkg::devSelT devSel,
	input logic refReq,
	output logic refAck,
	output logic ramReady,
	output warpPkg::raT ra,
	output logic nRas,
	output logic nCas,
	output logic nRamLwe,
	output logic nRamUwe,
	output logic nOe,
	output logic nRomOe
);

	warpPkg::ramStateT state;
	warpPkg::raT rowAddr;
	warpPkg::raT colAddr;
	logic refPending;

	// row is a21..a12 with the top ra bit zero
	assign rowAddr = warpPkg::raT'(addr[12 +: warpPkg::rowWidth]);
	// column is a11..a1
	assign colAddr = warpPkg::raT'(addr[1 +: warpPkg::colWidth]);
	// open request not yet acknowledged
	assign refPending = refReq && !refAck;

	always_ff @(posedge FCLK) begin
		if (reset) begin
			state <= warpPkg::ramIdle;
			refAck <= 1'b0;
			ramReady <= 1'b0;
			nRas <= 1'b1;
			nCas <= 1'b1;
			nRamLwe <= 1'b1;
			nRamUwe <= 1'b1;
			nOe <= 1'b1;
			nRomOe <= 1'b1;
		end else begin
			// return phase of the refresh handshake
			if (refAck && !refReq) begin
				refAck <= 1'b0;
			end
			case (state)
				warpPkg::ramIdle: begin
					// refresh wins, access waits here
					if (refPending) begin
						state <= warpPkg::refCas;
						nCas <= 1'b0;
					end else if (devSel == warpPkg::devRam) begin
						state <= warpPkg::ramRas;
						nRas <= 1'b0;
					end else if (devSel == warpPkg::devRom) begin
						state <= warpPkg::ramRomWait;
						// flash output only driven on reads
						nRomOe <= !nWe;
					end
				end
				warpPkg::ramRas: begin
					state <= warpPkg::ramCas;
					nCas <= 1'b0;
					ramReady <= 1'b1;
					// byte write enables only for writes
					nRamLwe <= nWe | nLds;
					nRamUwe <= nWe | nUds;
					nOe <= !nWe;
				end
				warpPkg::ramCas: begin
					state <= warpPkg::ramHold;
				end
				warpPkg::ramRomWait: begin
					state <= warpPkg::ramRomDone;
				end
				warpPkg::ramRomDone: begin
					state <= warpPkg::ramHold;
					ramReady <= 1'b1;
				end
				warpPkg::refCas: begin
					// cas before ras
					state <= warpPkg::refRas1;
					nCas <= 1'b1;
					nRas <= 1'b0;
				end
				warpPkg::refRas1: begin
					state <= warpPkg::refRas2;
				end
				warpPkg::refRas2: begin
					state <= warpPkg::ramIdle;
					nRas <= 1'b1;
					refAck <= 1'b1;
				end
				warpPkg::ramHold: begin
					// strobes stay until the cpu drops as
					if (devSel == warpPkg::devIdle) begin
						state <= warpPkg::ramIdle;
						ramReady <= 1'b0;
						nRas <= 1'b1;
						nCas <= 1'b1;
						nRamLwe <= 1'b1;
						nRamUwe <= 1'b1;
						nOe <= 1'b1;
						nRomOe <= 1'b1;
					end
				end
				default: begin
					state <= warpPkg::ramIdle;
				end
			endcase
		end
	end

	// row tracks the bus until ras, column latched with cas
	always_ff @(posedge FCLK) begin
		if (state == warpPkg::ramIdle) begin
			ra <= rowAddr;
		end else if (state == warpPkg::ramRas) begin
			ra <= colAddr;
		end
	end

endmodule

// ==== verilog/refreshTimer.sv ====
`timescale 1ns/1ps

module refreshTimer #(
	parameter int refreshPeriod = 64
)(
	input logic FCLK,
	input logic reset,
	output logic refReq,
	input logic refAck
);

	localparam int cntWidth = (refreshPeriod > 1) ? $clog2(refreshPeriod) : 1;

	logic [cntWidth-1:0] count;
	logic wrap;
	logic pending;
	logic start;

	assign wrap = (count == cntWidth'(refreshPeriod - 1));
	// new request only once the previous handshake is fully closed
	assign start = !refReq && !refAck && (wrap || pending);

	always_ff @(posedge FCLK) begin
		if (reset) begin
			count <= '0;
			refReq <= 1'b0;
			pending <= 1'b0;
		end else begin
			// free running
			count <= wrap ? '0 : count + 1'b1;
			if (refReq && refAck) begin
				refReq <= 1'b0;
			end else if (start) begin
				refReq <= 1'b1;
			end
			// wrap during an open request counts as one more
			if (start) begin
				pending <= pending && wrap;
			end else if (wrap) begin
				pending <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/chipSelect.sv ====
`timescale 1ns/1ps

module chipSelect(
	input logic FCLK,
	input logic reset,
	input warpPkg::addrT addr,
	input logic nAs,
	output warpPkg::devSelT devSel
);

	// address map on a23..a20
	function automatic warpPkg::devSelT decode(input warpPkg::addrT a);
		case (a[23:20])
			4'h0, 4'h1, 4'h2, 4'h3: decode = warpPkg::devRam;
			4'h4: decode = warpPkg::devRom;
			4'hE, 4'hF: decode = warpPkg::devIo;
			default: decode = warpPkg::devNone;
		endcase
	endfunction

	logic cycleStart;
	logic cycleEnd;

	// first edge with as low while no cycle is open
	assign cycleStart = !nAs && (devSel == warpPkg::devIdle);
	// any edge with as high closes the cycle
	assign cycleEnd = nAs;

	always_ff @(posedge FCLK) begin
		if (reset) begin
			devSel <= warpPkg::devIdle;
		end else if (cycleEnd) begin
			devSel <= warpPkg::devIdle;
		end else if (cycleStart) begin
			// target latched once, held for the whole cycle
			devSel <= decode(addr);
		end
	end

endmodule

// ==== verilog/ioReqIf.sv ====
`timescale 1ns/1ps

interface ioReqIf;
	// four-phase request and its acknowledge
	logic req;
	logic ack;
	// cycle attributes, active high, stable while req is high
	logic write;
	logic lds;
	logic uds;
	// bus error result, valid while ack is high
	logic berr;

	modport slave(output req, write, lds, uds, input ack, berr);

	modport master(input req, write, lds, uds, output ack, berr);

endinterface

// ==== verilog/warpPkg.sv ====
package warpPkg;

	// fsb word address, a0 replaced by byte strobes
	typedef logic [23:1] addrT;

	// multiplexed dram address pins
	typedef logic [10:0] raT;

	// row comes from a21..a12
	localparam int rowWidth = 10;
	// column comes from a11..a1
	localparam int colWidth = 11;

	// decoded target of the current fsb cycle
	typedef enum logic [2:0] {
		devIdle,
		devRam,
		devRom,
		devIo,
		devNone
	} devSelT;

	// dram and rom sequencer
	typedef enum logic [3:0] {
		ramIdle,
		ramRas,
		ramCas,
		ramRomWait,
		ramRomDone,
		refCas,
		refRas1,
		refRas2,
		ramHold
	} ramStateT;

	// peripheral bus master
	typedef enum logic [1:0] {
		ioIdle,
		ioStrobe,
		ioWait,
		ioAck
	} ioStateT;

endpackage
